//--- source/detector_pkg.sv
package detector_pkg;

    // Bits per block.
    localparam int default_width = 8;

    // Error samples summed per hypothesis; the channel has one more tap.
    localparam int default_seq_length = 3;

    // Width of a residual-error sample.
    localparam int default_err_bits = 8;

    // Width of a channel tap.
    localparam int default_chan_bits = 8;

    // Error hypothesis tested at each bit position.
    typedef enum logic [1:0] {
        cand_none        = 2'd0,
        cand_single_lead = 2'd1,
        cand_single_lag  = 2'd2,
        cand_double      = 2'd3
    } cand_t;

endpackage : detector_pkg

//--- source/window_if.sv
`timescale 1ns/1ps

interface window_if #(
    parameter int width = detector_pkg::default_width,
    parameter int err_bits = detector_pkg::default_err_bits
) ();

    // Strobe for one complete two-block window.
    logic valid;
    // Positions 0 to width-1 hold the older block.
    logic [2*width-1:0] bits;
    logic signed [err_bits-1:0] errs [2*width];
    // Toggles once per window.
    logic block_index;

    modport source (
        output valid, bits, errs, block_index
    );

    modport sink (
        input valid, bits, errs, block_index
    );

endinterface : window_if

//--- source/channel_config.sv
`timescale 1ns/1ps

module channel_config #(
    parameter int seq_length = detector_pkg::default_seq_length,
    parameter int chan_bits = detector_pkg::default_chan_bits
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  cfg_valid,
    input  logic [$clog2(seq_length+1)-1:0]       cfg_tap,
    input  logic signed [chan_bits-1:0]           cfg_value,
    output logic signed [chan_bits-1:0]           taps [seq_length+1]
);

    // One tap written per strobe, visible to the detector next cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int j = 0; j <= seq_length; j++) begin
                taps[j] <= '0;
            end
        end else if (cfg_valid) begin
            taps[cfg_tap] <= cfg_value;
        end
    end

    // Tap index must address an existing tap.
    cfg_tap_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        cfg_valid |-> (int'(cfg_tap) <= seq_length)
    ) else $error("cfg_tap %0d out of range", cfg_tap);

endmodule : channel_config

//--- source/stream_window.sv
`timescale 1ns/1ps

module stream_window #(
    parameter int width = detector_pkg::default_width,
    parameter int err_bits = detector_pkg::default_err_bits
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  logic [width-1:0]            in_bits,
    input  logic signed [err_bits-1:0]  in_errs [width],
    window_if.source                    win
);

    // Last block received, kept until the next one arrives.
    logic [width-1:0] prev_bits;
    logic signed [err_bits-1:0] prev_errs [width];
    logic have_prev;

    // Control state.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            have_prev <= 1'b0;
            win.valid <= 1'b0;
            win.block_index <= 1'b0;
        end else begin
            // First block after reset only fills the history.
            win.valid <= in_valid && have_prev;
            if (in_valid) begin
                have_prev <= 1'b1;
            end
            if (win.valid) begin
                win.block_index <= ~win.block_index;
            end
        end
    end

    // Payload: older block low, newer block high.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            win.bits <= {in_bits, prev_bits};
            for (int i = 0; i < width; i++) begin
                win.errs[i] <= prev_errs[i];
                win.errs[width + i] <= in_errs[i];
            end
            prev_bits <= in_bits;
            prev_errs <= in_errs;
        end
    end

    // A window always needs an older block behind it.
    window_needs_prev: assert property (
        @(posedge clk) disable iff (!rst_n)
        win.valid |-> have_prev
    ) else $error("window valid without a previous block");

endmodule : stream_window

//--- source/sliding_detector.sv
`timescale 1ns/1ps

module sliding_detector #(
    parameter int width = detector_pkg::default_width,
    parameter int seq_length = detector_pkg::default_seq_length,
    parameter int err_bits = detector_pkg::default_err_bits,
    parameter int chan_bits = detector_pkg::default_chan_bits
) (
    input  logic                        clk,
    input  logic                        rst_n,
    window_if.sink                      win,
    input  logic signed [chan_bits-1:0] taps [seq_length+1],
    output logic                        dec_valid,
    output detector_pkg::cand_t         dec_codes [width],
    output logic [width-1:0]            dec_bits
);

    import detector_pkg::*;

    // Sample plus up to two injected taps needs two extra bits.
    localparam int max_bits = (err_bits > chan_bits) ? err_bits : chan_bits;
    localparam int term_bits = max_bits + 2;
    localparam int sqr_bits = 2 * term_bits;
    localparam int sum_bits = sqr_bits + $clog2(seq_length + 1);

    // Error vector injected at each window position, signed by the decided bit.
    logic signed [term_bits-1:0] inj [width+1][seq_length+1];
    // Summed squared error per position and hypothesis.
    logic [sum_bits-1:0] metric [width][4];
    cand_t best_code [width];

    logic last_index;
    logic seen_window;

    function automatic logic [sqr_bits-1:0] square(input logic signed [term_bits-1:0] v);
        logic signed [sqr_bits-1:0] wide;
        wide = v;
        return $unsigned(wide * wide);
    endfunction

    always_comb begin
        for (int p = 0; p <= width; p++) begin
            for (int j = 0; j <= seq_length; j++) begin
                inj[p][j] = win.bits[p] ? term_bits'(taps[j]) : -term_bits'(taps[j]);
            end
        end
    end

    always_comb begin : sums
        logic signed [term_bits-1:0] r;
        r = '0;
        for (int i = 0; i < width; i++) begin
            for (int h = 0; h < 4; h++) begin
                metric[i][h] = '0;
            end
            for (int j = 0; j < seq_length; j++) begin
                r = term_bits'(win.errs[i + j]);
                metric[i][0] = metric[i][0] + sum_bits'(square(r));
                metric[i][1] = metric[i][1] + sum_bits'(square(r + inj[i][j + 1]));
                metric[i][2] = metric[i][2] + sum_bits'(square(r + inj[i + 1][j]));
                metric[i][3] = metric[i][3]
                             + sum_bits'(square(r + inj[i + 1][j] + inj[i][j + 1]));
            end
        end
    end

    // Minimum search; strict compare keeps the lowest code on a tie.
    always_comb begin : select
        logic [sum_bits-1:0] best_metric;
        best_metric = '0;
        for (int i = 0; i < width; i++) begin
            best_metric = metric[i][0];
            best_code[i] = cand_none;
            for (int h = 1; h < 4; h++) begin
                if (metric[i][h] < best_metric) begin
                    best_metric = metric[i][h];
                    best_code[i] = cand_t'(2'(h));
                end
            end
        end
    end

    // Control state, including the last window's block index.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            last_index <= 1'b0;
            seen_window <= 1'b0;
        end else begin
            dec_valid <= win.valid;
            if (win.valid) begin
                last_index <= win.block_index;
                seen_window <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (win.valid) begin
            dec_codes <= best_code;
            dec_bits <= win.bits[width-1:0];
        end
    end

    // Consecutive windows must slide by exactly one block.
    window_index_toggles: assert property (
        @(posedge clk) disable iff (!rst_n)
        (win.valid && seen_window) |-> (win.block_index != last_index)
    ) else $error("window block index did not advance");

endmodule : sliding_detector

//--- source/error_corrector.sv
`timescale 1ns/1ps

module error_corrector #(
    parameter int width = detector_pkg::default_width
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        dec_valid,
    input  detector_pkg::cand_t         dec_codes [width],
    input  logic [width-1:0]            dec_bits,
    output logic                        out_valid,
    output logic [width-1:0]            out_bits,
    output logic [$clog2(width+1)-1:0]  out_count
);

    import detector_pkg::*;

    logic [width-1:0] flip_mask;
    logic [$clog2(width+1)-1:0] flip_count;

    // Requests from neighbouring positions merge into one flip.
    always_comb begin
        flip_mask = '0;
        for (int i = 0; i < width; i++) begin
            if (dec_codes[i] == cand_single_lead || dec_codes[i] == cand_double) begin
                flip_mask[i] = 1'b1;
            end
            // A lag request past the last bit falls off the block.
            if ((dec_codes[i] == cand_single_lag || dec_codes[i] == cand_double)
                    && (i < width - 1)) begin
                flip_mask[i + 1] = 1'b1;
            end
        end
    end

    // Popcount of the mask.
    always_comb begin
        flip_count = '0;
        for (int i = 0; i < width; i++) begin
            flip_count = flip_count + ($clog2(width+1))'(flip_mask[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            out_bits <= dec_bits ^ flip_mask;
            out_count <= flip_count;
        end
    end

    // A block cannot lose more bits than it holds.
    count_bounded: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> (int'(out_count) <= width)
    ) else $error("out_count %0d exceeds block width", out_count);

endmodule : error_corrector

//--- source/detector_top.sv
`timescale 1ns/1ps

module detector_top #(
    parameter int width = detector_pkg::default_width,
    parameter int seq_length = detector_pkg::default_seq_length,
    parameter int err_bits = detector_pkg::default_err_bits,
    parameter int chan_bits = detector_pkg::default_chan_bits
) (
    input  logic                                clk,
    input  logic                                rst_n,

    // Block input.
    input  logic                                in_valid,
    input  logic [width-1:0]                    in_bits,
    input  logic signed [err_bits-1:0]          in_errs [width],

    // Tap configuration.
    input  logic                                cfg_valid,
    input  logic [$clog2(seq_length+1)-1:0]     cfg_tap,
    input  logic signed [chan_bits-1:0]         cfg_value,

    // Corrected block output.
    output logic                                out_valid,
    output logic [width-1:0]                    out_bits,
    output logic [$clog2(width+1)-1:0]          out_count
);

    import detector_pkg::*;

    logic signed [chan_bits-1:0] taps [seq_length+1];

    logic dec_valid;
    cand_t dec_codes [width];
    logic [width-1:0] dec_bits;

    window_if #(
        .width    (width),
        .err_bits (err_bits)
    ) win_bus ();

    channel_config #(
        .seq_length (seq_length),
        .chan_bits  (chan_bits)
    ) u_channel_config (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_valid (cfg_valid),
        .cfg_tap   (cfg_tap),
        .cfg_value (cfg_value),
        .taps      (taps)
    );

    stream_window #(
        .width    (width),
        .err_bits (err_bits)
    ) u_stream_window (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_bits  (in_bits),
        .in_errs  (in_errs),
        .win      (win_bus.source)
    );

    sliding_detector #(
        .width      (width),
        .seq_length (seq_length),
        .err_bits   (err_bits),
        .chan_bits  (chan_bits)
    ) u_sliding_detector (
        .clk       (clk),
        .rst_n     (rst_n),
        .win       (win_bus.sink),
        .taps      (taps),
        .dec_valid (dec_valid),
        .dec_codes (dec_codes),
        .dec_bits  (dec_bits)
    );

    error_corrector #(
        .width (width)
    ) u_error_corrector (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec_codes (dec_codes),
        .dec_bits  (dec_bits),
        .out_valid (out_valid),
        .out_bits  (out_bits),
        .out_count (out_count)
    );

endmodule : detector_top

//--- verification/tb_detector.sv
`timescale 1ns/1ps

module tb_detector;

    import detector_pkg::*;

    localparam int width = default_width;
    localparam int seq_length = default_seq_length;
    localparam int err_bits = default_err_bits;
    localparam int chan_bits = default_chan_bits;
    localparam int tap_idx_bits = $clog2(seq_length + 1);

    localparam int reset_cycles = 16;
    localparam int random_blocks = 300;
    localparam int total_blocks = 31 + 40 + random_blocks + 27;
    localparam int tap_loads = 8;
    // Up to two idle cycles per block, plus a drain before every tap load.
    localparam int cycle_limit = 2 * reset_cycles + tap_loads * (seq_length + 11)
                               + 3 * total_blocks + 3 + 200;

    logic clk;
    logic rst_n;
    logic in_valid;
    logic [width-1:0] in_bits;
    logic signed [err_bits-1:0] in_errs [width];
    logic cfg_valid;
    logic [tap_idx_bits-1:0] cfg_tap;
    logic signed [chan_bits-1:0] cfg_value;
    logic out_valid;
    logic [width-1:0] out_bits;
    logic [$clog2(width+1)-1:0] out_count;

    // Model of the DUT state seen from its ports.
    int tap_model [seq_length+1];
    logic [width-1:0] prev_bits;
    int prev_errs [width];
    bit have_prev;

    logic [width-1:0] exp_bits_q [$];
    int exp_count_q [$];
    int exp_cycle_q [$];
    int matched = 0;
    int cycle = 0;
    integer seed = 52;

    detector_top #(
        .width      (width),
        .seq_length (seq_length),
        .err_bits   (err_bits),
        .chan_bits  (chan_bits)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_bits   (in_bits),
        .in_errs   (in_errs),
        .cfg_valid (cfg_valid),
        .cfg_tap   (cfg_tap),
        .cfg_value (cfg_value),
        .out_valid (out_valid),
        .out_bits  (out_bits),
        .out_count (out_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > cycle_limit) begin
            $display("Timeout: test did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input longint actual, input longint expected);
        if (actual !== expected) begin
            $display("Error: time %0t signal %s got %0d expected %0d",
                     $time, name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // Corrected older block and flip count for one two-block window.
    function automatic void reference_correct(
        input logic [width-1:0] old_bits,
        input logic [width-1:0] new_bits,
        input int errs [2*width],
        input int taps [seq_length+1],
        output logic [width-1:0] fixed_bits,
        output int count
    );
        logic [2*width-1:0] win_bits;
        int sgn [2*width];
        int metric [4];
        int r;
        int t1;
        int t2;
        int t3;
        int best;
        logic [width-1:0] mask;
        win_bits = {new_bits, old_bits};
        for (int p = 0; p < 2 * width; p++) begin
            sgn[p] = win_bits[p] ? 1 : -1;
        end
        mask = '0;
        for (int i = 0; i < width; i++) begin
            for (int h = 0; h < 4; h++) begin
                metric[h] = 0;
            end
            for (int j = 0; j < seq_length; j++) begin
                r = errs[i + j];
                t1 = r + sgn[i] * taps[j + 1];
                t2 = r + sgn[i + 1] * taps[j];
                t3 = r + sgn[i + 1] * taps[j] + sgn[i] * taps[j + 1];
                metric[0] += r * r;
                metric[1] += t1 * t1;
                metric[2] += t2 * t2;
                metric[3] += t3 * t3;
            end
            // Lowest hypothesis wins a tie.
            best = 0;
            for (int h = 1; h < 4; h++) begin
                if (metric[h] < metric[best]) begin
                    best = h;
                end
            end
            if (best == 1 || best == 3) begin
                mask[i] = 1'b1;
            end
            if ((best == 2 || best == 3) && i < width - 1) begin
                mask[i + 1] = 1'b1;
            end
        end
        fixed_bits = old_bits ^ mask;
        count = 0;
        for (int i = 0; i < width; i++) begin
            count += int'(mask[i]);
        end
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            in_valid = 1'b0;
            cfg_valid = 1'b0;
        end
    endtask

    // Drives one block; the window it closes is predicted right away.
    task automatic send_block(input logic [width-1:0] bits, input int errs [width]);
        int window [2*width];
        logic [width-1:0] fixed;
        int count;
        @(posedge clk);
        #2;
        cfg_valid = 1'b0;
        in_valid = 1'b1;
        in_bits = bits;
        for (int i = 0; i < width; i++) begin
            in_errs[i] = err_bits'(errs[i]);
        end
        if (have_prev) begin
            for (int i = 0; i < width; i++) begin
                window[i] = prev_errs[i];
                window[width + i] = errs[i];
            end
            reference_correct(prev_bits, bits, window, tap_model, fixed, count);
            exp_bits_q.push_back(fixed);
            exp_count_q.push_back(count);
            exp_cycle_q.push_back(cycle);
        end
        prev_bits = bits;
        prev_errs = errs;
        have_prev = 1'b1;
    endtask

    task automatic write_tap(input int idx, input int value);
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        cfg_valid = 1'b1;
        cfg_tap = tap_idx_bits'(idx);
        cfg_value = chan_bits'(value);
        tap_model[idx] = value;
    endtask

    // Waits until every predicted block has come out.
    task automatic drain();
        while (exp_bits_q.size() != 0) begin
            idle(1);
        end
        idle(2);
    endtask

    task automatic load_taps(input int values [seq_length+1]);
        drain();
        for (int j = 0; j <= seq_length; j++) begin
            write_tap(j, values[j]);
        end
    endtask

    task automatic load_random_taps(input int limit);
        drain();
        for (int j = 0; j <= seq_length; j++) begin
            write_tap(j, $random(seed) % (limit + 1));
        end
    endtask

    task automatic send_random(input int count, input int err_limit, input int max_gap);
        int errs [width];
        for (int k = 0; k < count; k++) begin
            for (int i = 0; i < width; i++) begin
                errs[i] = $random(seed) % (err_limit + 1);
            end
            send_block(width'($random(seed)), errs);
            if (max_gap > 0) begin
                idle(($random(seed) & 32'h7fff_ffff) % (max_gap + 1));
            end
        end
    endtask

    task automatic reset_midstream();
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        in_valid = 1'b0;
        cfg_valid = 1'b0;
        exp_bits_q.delete();
        exp_count_q.delete();
        exp_cycle_q.delete();
        have_prev = 1'b0;
        for (int j = 0; j <= seq_length; j++) begin
            tap_model[j] = 0;
        end
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    initial begin : compare
        forever begin
            @(negedge clk);
            if (out_valid) begin
                if (exp_bits_q.size() == 0) begin
                    $display("Unexpected output block at time %0t with none expected", $time);
                    $display("STATUS: FAIL");
                    $fatal(1, "unexpected output");
                end else begin
                    check_value("out_bits", out_bits, exp_bits_q.pop_front());
                    check_value("out_count", out_count, exp_count_q.pop_front());
                    check_value("out_latency", cycle - exp_cycle_q.pop_front(), 3);
                    matched++;
                end
            end
        end
    end

    initial begin : stimulus
        int zeros [width];
        int errs [width];
        int tap_set [seq_length+1];
        logic [width-1:0] bits;
        int s0;
        int s1;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_bits = '0;
        cfg_valid = 1'b0;
        cfg_tap = '0;
        cfg_value = '0;
        have_prev = 1'b0;
        prev_bits = '0;
        for (int i = 0; i < width; i++) begin
            in_errs[i] = '0;
            zeros[i] = 0;
            prev_errs[i] = 0;
        end
        for (int j = 0; j <= seq_length; j++) begin
            tap_model[j] = 0;
        end
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Clean stream; a lone first block gives no output.
        send_block(8'ha5, zeros);
        idle(6);
        for (int k = 0; k < 6; k++) begin
            send_block(width'($random(seed)), zeros);
        end

        // Single error at q, also flagged as a lag error from q-1.
        tap_set = '{4, 40, 20, 10};
        load_taps(tap_set);
        for (int q = 0; q <= width - seq_length; q++) begin
            bits = width'($random(seed));
            s0 = bits[q] ? 1 : -1;
            errs = zeros;
            for (int j = 0; j < seq_length; j++) begin
                errs[q + j] = -s0 * tap_model[j + 1];
            end
            send_block(bits, errs);
            send_block(width'($random(seed)), zeros);
            check_value("single_count", exp_count_q[$], 1);
            check_value("single_flip", exp_bits_q[$] ^ bits, longint'(1) << q);
            idle(1);
        end

        // Adjacent double errors at q and q+1.
        for (int q = 0; q <= width - seq_length; q++) begin
            bits = width'($random(seed));
            s0 = bits[q] ? 1 : -1;
            s1 = bits[q + 1] ? 1 : -1;
            errs = zeros;
            for (int j = 0; j < seq_length; j++) begin
                errs[q + j] = -(s1 * tap_model[j] + s0 * tap_model[j + 1]);
            end
            send_block(bits, errs);
            send_block(width'($random(seed)), zeros);
            check_value("double_flip", (exp_bits_q[$] ^ bits) & (longint'(3) << q),
                        longint'(3) << q);
        end

        // Back-to-back, then with random gaps.
        send_random(20, 100, 0);
        send_random(20, 100, 2);

        // Small taps and errors on odd chunks give many ties.
        for (int c = 0; c < random_blocks / 50; c++) begin
            load_random_taps((c % 2 == 1) ? 3 : 100);
            send_random(50, (c % 2 == 1) ? 4 : 120, 2);
        end

        send_random(5, 100, 0);
        reset_midstream();
        send_random(1, 50, 0);
        idle(8);
        send_random(1, 50, 0);
        load_random_taps(60);
        send_random(20, 80, 1);

        drain();
        idle(5);
        if (exp_bits_q.size() == 0 && matched > 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("Run ended with %0d blocks checked and %0d still expected",
                     matched, exp_bits_q.size());
            $display("STATUS: FAIL");
            $fatal(1, "missing outputs");
        end
    end

endmodule : tb_detector

//--- sources.f
source/detector_pkg.sv
source/window_if.sv
source/channel_config.sv
source/stream_window.sv
source/sliding_detector.sv
source/error_corrector.sv
source/detector_top.sv
verification/tb_detector.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_detector
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= STATUS: PASS
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
